/* sdEngine_cfg.svh */
//////////////////////////////////////////////////
// SD engine configuration macros
// timing limits, command register codes,
// fixed command arguments, FIFO command indices
//////////////////////////////////////////////////

`ifndef SD_ENGINE_CFG_SVH
`define SD_ENGINE_CFG_SVH

// timing limits in sdClkIn cycles
`define SD_CMD0_WAIT       256
`define SD_RESP_TIMEOUT    256

// command register codes, index in the upper byte, response type below
`define SD_CREG_CMD0       16'h0000
`define SD_CREG_CMD8       16'h081A
`define SD_CREG_CMD55      16'h371A
`define SD_CREG_ACMD41     16'h2912   // r3, no crc check
`define SD_CREG_CMD2       16'h0209   // r2 long response
`define SD_CREG_CMD3       16'h031A
`define SD_CREG_CMD9       16'h0919   // r2 long response
`define SD_CREG_CMD7       16'h071A
`define SD_CREG_ACMD6      16'h061A
`define SD_CREG_CMD16      16'h101A
`define SD_CREG_CMD24      16'h181A
`define SD_CREG_CMD17      16'h111A

// fixed arguments
`define SD_ARG_IF_COND     32'h000001AA   // 2.7-3.6 V, check pattern AA
`define SD_ARG_OCR         32'h40FF8000   // HCS plus voltage window
`define SD_ARG_BUS4        32'h00000002
`define SD_BLOCK_LEN       32'h00000200
`define SD_ARG_CMD55_LOW   16'hAAAA

// command FIFO indices
`define SD_IDX_WRITE       6'd24
`define SD_IDX_READ        6'd17

`endif

/* sdPkg.sv */
//////////////////////////////////////////////////
// SD engine shared types
// command FIFO word, result FIFO word,
// command request and card response views
//////////////////////////////////////////////////

package sdPkg;

   // command FIFO word, 72 bits
   typedef struct packed {
      logic [7:0]  spareHi;
      logic [5:0]  index;      // 24 write, 17 read
      logic [7:0]  tag;        // echoed in the result word
      logic [17:0] spareLo;
      logic [31:0] blockAddr;
   } sdCmdWord_t;

   // result FIFO word, 36 bits
   typedef struct packed {
      logic [16:0] spareHi;
      logic [3:0]  dataStatus;
      logic        spareLo;
      logic [5:0]  respIndex;
      logic [7:0]  tag;
   } sdResult_t;

   // one command toward the command port
   typedef struct packed {
      logic        valid;      // single cycle
      logic        toEn;       // arm the response timeout
      logic [15:0] cmdReg;
      logic [31:0] arg;
   } sdCmdReq_t;

   // 48-bit response right aligned in the 136-bit frame
   typedef struct packed {
      logic [87:0] spare;
      logic [1:0]  startDir;
      logic [5:0]  index;
      logic [31:0] status;     // card status or OCR
      logic [7:0]  crcEnd;
   } sdShortResp_t;

   // card response, short view for r1/r3/r6, long view for r2
   typedef union packed {
      sdShortResp_t shortResp;
      logic [135:0] longResp;
   } sdResp_u;

endpackage

/* sdCmdPort.sv */
//////////////////////////////////////////////////
// SD command port
// request select between the two sequencers,
// command registers and newCmd pulse,
// response latch and response timeout
//////////////////////////////////////////////////

`include "sdEngine_cfg.svh"

module sdCmdPort (
   input  logic              sdClkIn,
   input  logic              initRst,
   input  logic              sdReady,
   input  sdPkg::sdCmdReq_t  initReq,
   input  sdPkg::sdCmdReq_t  xferReq,
   input  logic              dataReady,
   input  logic [135:0]      cmdResponse,
   output logic              newCmd,
   output logic [31:0]       argumentReg,
   output logic [15:0]       cmdReg,
   output sdPkg::sdResp_u    respReg,
   output logic              respDone,
   output logic              respTimeout,
   output logic              commandTimeOut
);

   import sdPkg::*;

   localparam int RespTimeout = `SD_RESP_TIMEOUT;
   localparam int ToWidth     = $clog2(RespTimeout) + 1;

   sdCmdReq_t          reqSel;
   logic               toArmed;   // waiting on a response with timeout
   logic [ToWidth-1:0] toCnt;

   // init sequencer owns the port until the card is ready
   assign reqSel = sdReady ? xferReq : initReq;

   //////////////////////////////////////////////////
   // card side registers
   //////////////////////////////////////////////////

   always_ff @(posedge sdClkIn) begin
      if (reqSel.valid) begin
         argumentReg <= reqSel.arg;
         cmdReg      <= reqSel.cmdReg;
      end
   end

   always_ff @(posedge sdClkIn) begin
      if (dataReady) begin
         respReg.longResp <= cmdResponse;   // whole frame, view chosen by reader
      end
   end

   //////////////////////////////////////////////////
   // handshake and timeout
   //////////////////////////////////////////////////

   always_ff @(posedge sdClkIn or posedge initRst) begin
      if (initRst) begin
         newCmd         <= 1'b0;
         respDone       <= 1'b0;
         respTimeout    <= 1'b0;
         commandTimeOut <= 1'b0;
         toArmed        <= 1'b0;
         toCnt          <= '0;
      end
      else begin
         newCmd      <= reqSel.valid;
         respDone    <= dataReady;    // respReg is settled by now
         respTimeout <= 1'b0;
         if (reqSel.valid) begin
            toArmed        <= reqSel.toEn;
            toCnt          <= '0;
            commandTimeOut <= 1'b0;
         end
         else if (toArmed) begin
            if (dataReady) begin
               toArmed <= 1'b0;
            end
            else if (toCnt == ToWidth'(RespTimeout - 1)) begin
               toArmed        <= 1'b0;
               respTimeout    <= 1'b1;
               commandTimeOut <= 1'b1;   // sticky until next command
            end
            else begin
               toCnt <= toCnt + 1'b1;
            end
         end
      end
   end

endmodule

/* sdInitSeq.sv */
//////////////////////////////////////////////////
// SD card bring-up sequencer
// CMD0, CMD8, ACMD41 polling, CMD2, CMD3, CMD9,
// CMD7, ACMD6 and CMD16, with RCA capture
//////////////////////////////////////////////////

`include "sdEngine_cfg.svh"

module sdInitSeq (
   input  logic              sdClkIn,
   input  logic              initRst,
   input  logic              initDone,
   input  sdPkg::sdResp_u    respReg,
   input  logic              respDone,
   input  logic              respTimeout,
   output sdPkg::sdCmdReq_t  initReq,
   output logic              sdReady
);

   import sdPkg::*;

   localparam int Cmd0Wait = `SD_CMD0_WAIT;
   localparam int CntWidth = $clog2(Cmd0Wait) + 1;

   typedef enum logic [4:0] {
      stIdle, stSendCmd0, stCmd0Wait, stSendCmd8, stCmd8Wait,
      stSendCmd55, stCmd55Wait, stSendAcmd41, stAcmd41Wait,
      stSendCmd2, stCmd2Wait, stSendCmd3, stCmd3Wait,
      stSendCmd9, stCmd9Wait, stSendCmd7, stCmd7Wait,
      stSendAcmd6, stAcmd6Wait, stSendCmd16, stCmd16Wait, stReady
   } initState_t;

   initState_t          state;
   logic [CntWidth-1:0] waitCnt;      // idle time after CMD0
   logic                acmd41Done;   // card left busy
   logic                acmd6Done;    // 4-bit bus set
   logic [15:0]         rca;

   function automatic sdCmdReq_t mkReq(input logic toEn, input logic [15:0] creg,
                                       input logic [31:0] arg);
      sdCmdReq_t req;
      req.valid  = 1'b1;
      req.toEn   = toEn;
      req.cmdReg = creg;
      req.arg    = arg;
      return req;
   endfunction

   assign sdReady = (state == stReady);

   // one request per send state
   always_comb begin
      initReq = '0;
      case (state)
         stSendCmd0:   initReq = mkReq(1'b0, `SD_CREG_CMD0, 32'h0);
         stSendCmd8:   initReq = mkReq(1'b1, `SD_CREG_CMD8, `SD_ARG_IF_COND);
         stSendCmd55:  initReq = mkReq(1'b1, `SD_CREG_CMD55, {rca, `SD_ARG_CMD55_LOW});
         stSendAcmd41: initReq = mkReq(1'b0, `SD_CREG_ACMD41, `SD_ARG_OCR);
         stSendCmd2:   initReq = mkReq(1'b0, `SD_CREG_CMD2, 32'h0);
         stSendCmd3:   initReq = mkReq(1'b0, `SD_CREG_CMD3, 32'h0);
         stSendCmd9:   initReq = mkReq(1'b0, `SD_CREG_CMD9, {rca, 16'h0});
         stSendCmd7:   initReq = mkReq(1'b0, `SD_CREG_CMD7, {rca, 16'h0});
         stSendAcmd6:  initReq = mkReq(1'b0, `SD_CREG_ACMD6, `SD_ARG_BUS4);
         stSendCmd16:  initReq = mkReq(1'b0, `SD_CREG_CMD16, `SD_BLOCK_LEN);
         default:      initReq = '0;
      endcase
   end

   //////////////////////////////////////////////////
   // bring-up FSM
   //////////////////////////////////////////////////

   always_ff @(posedge sdClkIn or posedge initRst) begin
      if (initRst) begin
         state      <= stIdle;
         waitCnt    <= '0;
         acmd41Done <= 1'b0;
         acmd6Done  <= 1'b0;
         rca        <= 16'h0;
      end
      else begin
         case (state)
            stIdle: if (initDone) state <= stSendCmd0;
            stSendCmd0: begin
               waitCnt    <= '0;
               acmd41Done <= 1'b0;   // restart from scratch
               acmd6Done  <= 1'b0;
               rca        <= 16'h0;
               state      <= stCmd0Wait;
            end
            stCmd0Wait: begin
               waitCnt <= waitCnt + 1'b1;
               if (waitCnt == CntWidth'(Cmd0Wait - 2)) state <= stSendCmd8;
            end
            stSendCmd8: state <= stCmd8Wait;
            stCmd8Wait: begin
               if (respTimeout) state <= stSendCmd0;
               else if (respDone) state <= stSendCmd55;
            end
            stSendCmd55: state <= stCmd55Wait;
            stCmd55Wait: begin
               if (respTimeout) state <= stSendCmd0;
               else if (respDone) begin
                  if (!acmd41Done) state <= stSendAcmd41;
                  else if (!acmd6Done) state <= stSendAcmd6;
                  else state <= stSendCmd16;
               end
            end
            stSendAcmd41: state <= stAcmd41Wait;
            stAcmd41Wait: begin
               if (respDone) begin
                  // OCR bit 31 set once power-up is complete
                  acmd41Done <= respReg.shortResp.status[31];
                  state <= respReg.shortResp.status[31] ? stSendCmd2 : stSendCmd55;
               end
            end
            stSendCmd2: state <= stCmd2Wait;
            stCmd2Wait: if (respDone) state <= stSendCmd3;
            stSendCmd3: state <= stCmd3Wait;
            stCmd3Wait: begin
               if (respDone) begin
                  rca   <= respReg.shortResp.status[31:16];   // r6 published RCA
                  state <= stSendCmd9;
               end
            end
            stSendCmd9: state <= stCmd9Wait;
            stCmd9Wait: if (respDone) state <= stSendCmd7;
            stSendCmd7: state <= stCmd7Wait;
            stCmd7Wait: if (respDone) state <= stSendCmd55;
            stSendAcmd6: state <= stAcmd6Wait;
            stAcmd6Wait: begin
               if (respDone) begin
                  acmd6Done <= 1'b1;
                  state     <= stSendCmd16;
               end
            end
            stSendCmd16: state <= stCmd16Wait;
            stCmd16Wait: if (respDone) state <= stReady;
            default: state <= stReady;
         endcase
      end
   end

endmodule

/* sdXferCtrl.sv */
//////////////////////////////////////////////////
// SD block transfer dispatcher
// command FIFO pop and decode, CMD24/CMD17 issue,
// data engine start and result FIFO write
//////////////////////////////////////////////////

`include "sdEngine_cfg.svh"

module sdXferCtrl (
   input  logic              sdClkIn,
   input  logic              initRst,
   input  logic              sdReady,
   input  sdPkg::sdCmdWord_t cmdFifoDataOut,
   input  logic              cmdFifoEmpty,
   input  sdPkg::sdResp_u    respReg,
   input  logic              respDone,
   input  logic              writeDone,
   input  logic              readDone,
   input  logic [3:0]        dataStatus,
   input  logic              writeFifoAlmostEmpty,
   input  logic              readFifoAlmostFull,
   input  logic              resultFifoFull,
   output sdPkg::sdCmdReq_t  xferReq,
   output logic              cmdFifoRdEn,
   output logic              writeCmd,
   output logic              readCmd,
   output sdPkg::sdResult_t  resultFifoDataIn,
   output logic              resultFifoWrEn
);

   import sdPkg::*;

   typedef enum logic [3:0] {
      xfIdle, xfPop, xfGap, xfDecode, xfHold,
      xfCmd, xfResp, xfStart, xfDataWait, xfResult
   } xferState_t;

   xferState_t state;
   sdCmdWord_t cmdWord;      // word being served
   logic [3:0] dataStat;
   logic       isRead;
   logic       dataHold;     // data FIFO not ready for a block
   logic       engineDone;

   assign isRead     = (cmdWord.index == `SD_IDX_READ);
   assign dataHold   = isRead ? readFifoAlmostFull : writeFifoAlmostEmpty;
   assign engineDone = isRead ? readDone : writeDone;

   assign cmdFifoRdEn    = (state == xfPop);
   assign writeCmd       = (state == xfStart) && !isRead;
   assign readCmd        = (state == xfStart) && isRead;
   assign resultFifoWrEn = (state == xfResult) && !resultFifoFull;

   // block command, argument is the block address
   always_comb begin
      xferReq = '0;
      if (state == xfCmd) begin
         xferReq.valid  = 1'b1;
         xferReq.cmdReg = isRead ? `SD_CREG_CMD17 : `SD_CREG_CMD24;
         xferReq.arg    = cmdWord.blockAddr;
      end
   end

   always_comb begin
      resultFifoDataIn            = '0;
      resultFifoDataIn.dataStatus = dataStat;
      resultFifoDataIn.respIndex  = respReg.shortResp.index;   // last response is ours
      resultFifoDataIn.tag        = cmdWord.tag;
   end

   //////////////////////////////////////////////////
   // dispatcher FSM
   //////////////////////////////////////////////////

   always_ff @(posedge sdClkIn or posedge initRst) begin
      if (initRst) begin
         state <= xfIdle;
      end
      else begin
         case (state)
            xfIdle:   if (sdReady && !cmdFifoEmpty) state <= xfPop;
            xfPop:    state <= xfGap;
            xfGap:    state <= xfDecode;   // let the FIFO output settle
            xfDecode: begin
               if (cmdFifoDataOut.index == `SD_IDX_WRITE ||
                   cmdFifoDataOut.index == `SD_IDX_READ) begin
                  state <= xfHold;
               end
               else begin
                  state <= xfIdle;         // unknown index is dropped
               end
            end
            xfHold:     if (!dataHold) state <= xfCmd;
            xfCmd:      state <= xfResp;
            xfResp:     if (respDone) state <= xfStart;
            xfStart:    state <= xfDataWait;
            xfDataWait: if (engineDone) state <= xfResult;
            xfResult:   if (!resultFifoFull) state <= xfIdle;
            default:    state <= xfIdle;
         endcase
      end
   end

   always_ff @(posedge sdClkIn) begin
      if (state == xfDecode) begin
         cmdWord <= cmdFifoDataOut;
      end
      if (state == xfDataWait && engineDone) begin
         dataStat <= dataStatus;   // status of the finished block
      end
   end

endmodule

/* sdEngine.sv */
//////////////////////////////////////////////////
// SD engine top level
// command port, bring-up sequencer and
// block transfer dispatcher
//////////////////////////////////////////////////

module sdEngine (
   input  logic              sdClkIn,
   input  logic              initRst,
   input  logic              initDone,
   input  logic              dataReady,
   input  logic [135:0]      cmdResponse,
   input  sdPkg::sdCmdWord_t cmdFifoDataOut,
   input  logic              cmdFifoEmpty,
   input  logic              resultFifoFull,
   input  logic              writeDone,
   input  logic              readDone,
   input  logic [3:0]        dataStatus,
   input  logic              writeFifoAlmostEmpty,
   input  logic              readFifoAlmostFull,
   output logic              newCmd,
   output logic [31:0]       argumentReg,
   output logic [15:0]       cmdReg,
   output logic              commandTimeOut,
   output sdPkg::sdResp_u    cmdResponseInt,
   output logic              sdReady,
   output logic              cmdFifoRdEn,
   output sdPkg::sdResult_t  resultFifoDataIn,
   output logic              resultFifoWrEn,
   output logic              writeCmd,
   output logic              readCmd
);

   import sdPkg::*;

   sdCmdReq_t initReq;
   sdCmdReq_t xferReq;
   logic      respDone;
   logic      respTimeout;

   sdCmdPort u_cmdPort (
      .sdClkIn        (sdClkIn),
      .initRst        (initRst),
      .sdReady        (sdReady),
      .initReq        (initReq),
      .xferReq        (xferReq),
      .dataReady      (dataReady),
      .cmdResponse    (cmdResponse),
      .newCmd         (newCmd),
      .argumentReg    (argumentReg),
      .cmdReg         (cmdReg),
      .respReg        (cmdResponseInt),
      .respDone       (respDone),
      .respTimeout    (respTimeout),
      .commandTimeOut (commandTimeOut)
   );

   sdInitSeq u_initSeq (
      .sdClkIn     (sdClkIn),
      .initRst     (initRst),
      .initDone    (initDone),
      .respReg     (cmdResponseInt),
      .respDone    (respDone),
      .respTimeout (respTimeout),
      .initReq     (initReq),
      .sdReady     (sdReady)
   );

   sdXferCtrl u_xferCtrl (
      .sdClkIn              (sdClkIn),
      .initRst              (initRst),
      .sdReady              (sdReady),
      .cmdFifoDataOut       (cmdFifoDataOut),
      .cmdFifoEmpty         (cmdFifoEmpty),
      .respReg              (cmdResponseInt),
      .respDone             (respDone),
      .writeDone            (writeDone),
      .readDone             (readDone),
      .dataStatus           (dataStatus),
      .writeFifoAlmostEmpty (writeFifoAlmostEmpty),
      .readFifoAlmostFull   (readFifoAlmostFull),
      .resultFifoFull       (resultFifoFull),
      .xferReq              (xferReq),
      .cmdFifoRdEn          (cmdFifoRdEn),
      .writeCmd             (writeCmd),
      .readCmd              (readCmd),
      .resultFifoDataIn     (resultFifoDataIn),
      .resultFifoWrEn       (resultFifoWrEn)
   );

endmodule

/* sdEngine_assert.sv */
//////////////////////////////////////////////////
// command port protocol assertions
// bound into every sdCmdPort instance
//////////////////////////////////////////////////

`include "sdEngine_cfg.svh"

module sdEngine_assert (
   input logic              sdClkIn,
   input logic              initRst,
   input logic              sdReady,
   input sdPkg::sdCmdReq_t  xferReq,
   input logic              newCmd,
   input logic              respTimeout
);

   // single-cycle strobe from either sequencer
   aNewCmdPulse: assert property (@(posedge sdClkIn) disable iff (initRst) newCmd |=> !newCmd)
      else $error("newCmd held for more than one cycle");

   // block commands only once bring-up is over
   aXferOwner: assert property (@(posedge sdClkIn) disable iff (initRst)
                                xferReq.valid |-> sdReady)
      else $error("block command requested before the card was ready");

   // timeout counted from the command strobe
   aToDelay: assert property (@(posedge sdClkIn) disable iff (initRst)
                              respTimeout |-> $past(newCmd, `SD_RESP_TIMEOUT))
      else $error("respTimeout not at the expected distance from newCmd");

endmodule

bind sdCmdPort sdEngine_assert u_assert (
   .sdClkIn     (sdClkIn),
   .initRst     (initRst),
   .sdReady     (sdReady),
   .xferReq     (xferReq),
   .newCmd      (newCmd),
   .respTimeout (respTimeout)
);

/* tbSdEngine.sv */
//////////////////////////////////////////////////
// testbench for the SD engine
// card model, bring-up and transfer tables,
// immediate checks and a cycle limit
//////////////////////////////////////////////////

`include "sdEngine_cfg.svh"

module tbSdEngine;

   import sdPkg::*;

   localparam int NumInit = 15;
   localparam int NumXfer = 5;
   localparam logic [15:0] Rca = 16'h1234;
   localparam int CycleLimit = 2 * `SD_CMD0_WAIT + `SD_RESP_TIMEOUT + NumInit * 16
                               + NumXfer * 64 + 300;
   localparam logic [135:0] CidFrame = {8'h3F, 120'h01_0203_0405_0607_0809_0A0B_0C0D_0E0F, 8'h01};
   localparam logic [135:0] CsdFrame = {8'h3F, 120'h40_0E00_325B_5900_00ED_C87F_800A_4000, 8'h01};

   typedef struct packed {
      logic [15:0]  creg;
      logic [31:0]  arg;
      logic [135:0] resp;
      logic         noReply;
   } initRow_t;

   typedef struct packed {
      sdCmdWord_t word;
      logic [7:0] holdCyc;    // data FIFO flag held this long
      logic [7:0] fullCyc;    // result FIFO full this long
      logic [3:0] dStat;
      sdResult_t  expRes;
   } xferRow_t;

   logic sdClkIn, initRst, initDone, dataReady, cmdFifoEmpty, resultFifoFull;
   logic writeDone, readDone, writeFifoAlmostEmpty, readFifoAlmostFull;
   logic [135:0] cmdResponse;
   logic [3:0]   dataStatus;
   sdCmdWord_t   cmdFifoDataOut;
   logic newCmd, commandTimeOut, sdReady, cmdFifoRdEn, resultFifoWrEn, writeCmd, readCmd;
   logic [31:0]  argumentReg;
   logic [15:0]  cmdReg;
   sdResp_u      cmdResponseInt;
   sdResult_t    resultFifoDataIn;

   initRow_t initTab [NumInit];
   xferRow_t xferTab [NumXfer];
   int errCount = 0;
   int checkCount = 0;
   int cycleCnt = 0;
   int resCount = 0;
   int expResCount = 0;
   int cmdCyc, cmd0Cyc, startCyc;
   logic readyAtCmd;
   integer seed = 2;

   sdEngine u_dut (.*);

   initial begin
      sdClkIn = 1'b0;
      forever #50 sdClkIn = ~sdClkIn;
   end

   always @(posedge sdClkIn) begin
      cycleCnt <= cycleCnt + 1;
      if (cycleCnt >= CycleLimit) begin
         $display("run stopped at the cycle limit of %0d with %0d errors", CycleLimit, errCount);
         $display("TESTS FAILED");
         $finish;
      end
   end

   always @(negedge sdClkIn) if (!initRst && resultFifoWrEn) resCount <= resCount + 1;

   task automatic checkEq(input logic [135:0] got, input logic [135:0] exp, input string what);
      checkCount++;
      assert (got === exp) else begin
         errCount++;
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkTrue(input logic cond, input string what);
      checkCount++;
      assert (cond === 1'b1) else begin
         errCount++;
         $display("ERR %0t: %s", $time, what);
      end
   endtask

   function automatic int randDelay();
      return 1 + ($unsigned($random(seed)) % 6);
   endfunction

   // r1/r3/r6/r7 frame, right aligned
   function automatic logic [135:0] shortFrame(input logic [5:0] idx, input logic [31:0] status);
      sdResp_u r;
      r = '0;
      r.shortResp.index  = idx;
      r.shortResp.status = status;
      r.shortResp.crcEnd = 8'h01;
      return r.longResp;
   endfunction

   function automatic sdCmdWord_t mkWord(input logic [5:0] idx, input logic [7:0] tag,
                                         input logic [31:0] addr);
      sdCmdWord_t w;
      w = '0;
      w.index     = idx;
      w.tag       = tag;
      w.blockAddr = addr;
      return w;
   endfunction

   function automatic sdResult_t packResult(input logic [3:0] ds, input logic [5:0] idx,
                                            input logic [7:0] tag);
      return {17'h0, ds, 1'b0, idx, tag};
   endfunction

   //////////////////////////////////////////////////
   // stimulus tables
   //////////////////////////////////////////////////

   task automatic loadTables();
      initTab[0]  = '{`SD_CREG_CMD0, 32'h0, 136'h0, 1'b1};
      initTab[1]  = '{`SD_CREG_CMD8, `SD_ARG_IF_COND, 136'h0, 1'b1};   // no reply, timeout
      initTab[2]  = '{`SD_CREG_CMD0, 32'h0, 136'h0, 1'b1};
      initTab[3]  = '{`SD_CREG_CMD8, `SD_ARG_IF_COND, shortFrame(6'd8, 32'h1AA), 1'b0};
      initTab[4]  = '{`SD_CREG_CMD55, {16'h0, `SD_ARG_CMD55_LOW}, shortFrame(6'd55, 32'h120), 1'b0};
      initTab[5]  = '{`SD_CREG_ACMD41, `SD_ARG_OCR, shortFrame(6'h3F, 32'h00FF8000), 1'b0};
      initTab[6]  = '{`SD_CREG_CMD55, {16'h0, `SD_ARG_CMD55_LOW}, shortFrame(6'd55, 32'h120), 1'b0};
      initTab[7]  = '{`SD_CREG_ACMD41, `SD_ARG_OCR, shortFrame(6'h3F, 32'hC0FF8000), 1'b0};
      initTab[8]  = '{`SD_CREG_CMD2, 32'h0, CidFrame, 1'b0};
      initTab[9]  = '{`SD_CREG_CMD3, 32'h0, shortFrame(6'd3, {Rca, 16'h0500}), 1'b0};
      initTab[10] = '{`SD_CREG_CMD9, {Rca, 16'h0}, CsdFrame, 1'b0};
      initTab[11] = '{`SD_CREG_CMD7, {Rca, 16'h0}, shortFrame(6'd7, 32'h700), 1'b0};
      initTab[12] = '{`SD_CREG_CMD55, {Rca, `SD_ARG_CMD55_LOW}, shortFrame(6'd55, 32'h920), 1'b0};
      initTab[13] = '{`SD_CREG_ACMD6, `SD_ARG_BUS4, shortFrame(6'd6, 32'h920), 1'b0};
      initTab[14] = '{`SD_CREG_CMD16, `SD_BLOCK_LEN, shortFrame(6'd16, 32'h920), 1'b0};
      xferTab[0] = '{mkWord(6'd24, 8'h11, 32'h0000_1000), 8'd8, 8'd0, 4'h0,
                     packResult(4'h0, 6'd24, 8'h11)};
      xferTab[1] = '{mkWord(6'd17, 8'h22, 32'h0000_2040), 8'd10, 8'd4, 4'h3,
                     packResult(4'h3, 6'd17, 8'h22)};
      xferTab[2] = '{mkWord(6'd9, 8'h33, 32'h0000_3000), 8'd0, 8'd0, 4'h0, 36'h0};   // dropped
      xferTab[3] = '{mkWord(6'd24, 8'h44, 32'h00AB_CDEF), 8'd0, 8'd3, 4'hA,
                     packResult(4'hA, 6'd24, 8'h44)};
      xferTab[4] = '{mkWord(6'd17, 8'h55, 32'hFFFF_FE00), 8'd0, 8'd0, 4'h1,
                     packResult(4'h1, 6'd17, 8'h55)};
      expResCount = 4;
   endtask

   // card model, one command and its answer
   task automatic answerCmd(input logic [15:0] creg, input logic [31:0] arg,
                            input logic [135:0] resp, input logic noReply, input string what);
      @(negedge sdClkIn);
      while (!newCmd) @(negedge sdClkIn);
      cmdCyc     = cycleCnt;
      readyAtCmd = sdReady;
      checkEq(cmdReg, creg, {what, " cmdReg"});
      checkEq(argumentReg, arg, {what, " argument"});
      if (!noReply) begin
         repeat (randDelay()) @(posedge sdClkIn);
         dataReady   <= 1'b1;
         cmdResponse <= resp;
         @(posedge sdClkIn);
         dataReady <= 1'b0;
         @(negedge sdClkIn);
         checkEq(cmdResponseInt, resp, {what, " latched response"});
      end
      else if (creg != `SD_CREG_CMD0) begin
         while (!commandTimeOut) @(negedge sdClkIn);   // CMD0 never answers
      end
   endtask

   task automatic runXfer(input xferRow_t row);
      logic isWr;
      logic isRd;
      isWr = (row.word.index == `SD_IDX_WRITE);
      isRd = (row.word.index == `SD_IDX_READ);
      @(posedge sdClkIn);
      cmdFifoDataOut       <= row.word;
      cmdFifoEmpty         <= 1'b0;
      writeFifoAlmostEmpty <= isWr && (row.holdCyc != 0);
      readFifoAlmostFull   <= isRd && (row.holdCyc != 0);
      resultFifoFull       <= (row.fullCyc != 0);
      @(negedge sdClkIn);
      while (!cmdFifoRdEn) @(negedge sdClkIn);
      @(posedge sdClkIn);
      cmdFifoEmpty <= 1'b1;   // word stays on the FIFO output
      if (!isWr && !isRd) begin
         repeat (12) begin
            @(negedge sdClkIn);
            checkTrue(!newCmd && !writeCmd && !readCmd && !resultFifoWrEn,
                      "unknown index started a transfer");
         end
      end
      else begin
         repeat (row.holdCyc) begin
            @(negedge sdClkIn);
            checkTrue(!newCmd, "block command issued under data FIFO hold");
         end
         @(posedge sdClkIn);
         writeFifoAlmostEmpty <= 1'b0;
         readFifoAlmostFull   <= 1'b0;
         answerCmd(isWr ? `SD_CREG_CMD24 : `SD_CREG_CMD17, row.word.blockAddr,
                   shortFrame(row.word.index, 32'h900), 1'b0, "block command");
         @(negedge sdClkIn);
         while (!(writeCmd || readCmd)) @(negedge sdClkIn);
         checkEq(writeCmd, isWr, "writeCmd");
         checkEq(readCmd, isRd, "readCmd");
         repeat (randDelay()) @(posedge sdClkIn);
         writeDone  <= isWr;
         readDone   <= isRd;
         dataStatus <= row.dStat;
         @(posedge sdClkIn);
         writeDone  <= 1'b0;
         readDone   <= 1'b0;
         dataStatus <= ~row.dStat;
         if (row.fullCyc != 0) begin
            repeat (row.fullCyc) begin
               @(negedge sdClkIn);
               checkTrue(!resultFifoWrEn, "result written while result FIFO full");
            end
            @(posedge sdClkIn);
            resultFifoFull <= 1'b0;
         end
         @(negedge sdClkIn);
         while (!resultFifoWrEn) @(negedge sdClkIn);
         checkEq(resultFifoDataIn, row.expRes, "result word");
      end
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////

   initial begin
      initRst = 1'b1;
      initDone = 1'b0;
      dataReady = 1'b0;
      cmdResponse = '0;
      cmdFifoDataOut = '0;
      cmdFifoEmpty = 1'b1;
      resultFifoFull = 1'b0;
      writeDone = 1'b0;
      readDone = 1'b0;
      dataStatus = 4'h0;
      writeFifoAlmostEmpty = 1'b0;
      readFifoAlmostFull = 1'b0;
      loadTables();
      repeat (16) @(posedge sdClkIn);
      initRst <= 1'b0;
      @(negedge sdClkIn);
      checkTrue(!newCmd && !writeCmd && !readCmd && !cmdFifoRdEn && !resultFifoWrEn
                && !sdReady && !commandTimeOut, "control outputs not low after reset");
      @(posedge sdClkIn);
      initDone <= 1'b1;
      @(negedge sdClkIn);
      startCyc = cycleCnt;
      for (int i = 0; i < NumInit; i++) begin
         answerCmd(initTab[i].creg, initTab[i].arg, initTab[i].resp, initTab[i].noReply,
                   "bring-up");
         checkTrue(!readyAtCmd, "sdReady high during bring-up");
         if (i == 0) checkTrue(cmdCyc - startCyc <= 3, "CMD0 late after initDone");
         if (initTab[i].creg == `SD_CREG_CMD0) cmd0Cyc = cmdCyc;
         if (initTab[i].creg == `SD_CREG_CMD8) begin
            checkTrue(cmdCyc - cmd0Cyc <= `SD_CMD0_WAIT + 2 &&
                      cmdCyc - cmd0Cyc >= `SD_CMD0_WAIT - 2, "CMD0 to CMD8 spacing");
         end
      end
      while (!sdReady) @(negedge sdClkIn);
      for (int i = 0; i < NumXfer; i++) runXfer(xferTab[i]);
      repeat (10) @(negedge sdClkIn);
      checkEq(resCount, expResCount, "result word count");
      $display("checks %0d errors %0d", checkCount, errCount);
      if (errCount == 0) begin
         $display("TESTS PASSED");
      end
      else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* sdEngine.f */
+incdir+.
sdPkg.sv
sdCmdPort.sv
sdInitSeq.sv
sdXferCtrl.sv
sdEngine.sv
sdEngine_assert.sv
tbSdEngine.sv

/* Bender.yml */
package:
  name: sdEngine

sources:
  - include_dirs:
      - .
    files:
      - sdPkg.sv
      - sdCmdPort.sv
      - sdInitSeq.sv
      - sdXferCtrl.sv
      - sdEngine.sv
  - target: test
    include_dirs:
      - .
    files:
      - sdEngine_assert.sv
      - tbSdEngine.sv
